// ==== source/adder_pkg.sv ====
package adder_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath geometry
  ////////////////////////////////////////////////////////////

  // Operand and result width, a power of two up to 64
  localparam int DATA_W = 32;

  // One prefix level per doubling of the group span
  localparam int PREFIX_LEVELS = $clog2(DATA_W);

  // Operands, sums and results
  typedef logic [DATA_W-1:0] data_t;

endpackage

// ==== source/arith_pkg.sv ====
package arith_pkg;

  ////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_ADC = 2'b01,
    OP_SUB = 2'b10,
    OP_SBB = 2'b11
  } op_t;

  ////////////////////////////////////////////////////////////
  // Result flags
  ////////////////////////////////////////////////////////////

  typedef logic [3:0] flags_t;

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // Cycles from in_valid to out_valid
  localparam int PIPE_LATENCY = 2;

endpackage

// ==== source/adder_if.sv ====
interface adder_if import adder_pkg::*; ();

  // Operands and carry in from the arithmetic stage
  data_t op_a;
  data_t op_b;
  logic  cin;

  // Adder answer, same cycle
  data_t sum;
  logic  cout;

  modport stage (
    output op_a, op_b, cin,
    input  sum, cout
  );

  modport adder (
    input  op_a, op_b, cin,
    output sum, cout
  );

endinterface

// ==== source/brent_kung_adder.sv ====
module brent_kung_adder import adder_pkg::*; (
  adder_if.adder bus
);

  // Up-sweep terms, level 0 is the bitwise generate/propagate
  data_t gu [PREFIX_LEVELS+1];
  data_t pu [PREFIX_LEVELS+1];

  // Down-sweep generate terms, level PREFIX_LEVELS is the up-sweep result
  data_t gd [1:PREFIX_LEVELS];

  // Carry into each bit position
  data_t carry_in;

  genvar lv;
  genvar i;

  ////////////////////////////////////////////////////////////
  // Bitwise generate and propagate
  ////////////////////////////////////////////////////////////

  assign pu[0] = bus.op_a ^ bus.op_b;

  // cin folded into bit 0 so every prefix includes it
  assign gu[0][0] = (bus.op_a[0] & bus.op_b[0]) | (pu[0][0] & bus.cin);

  for (i = 1; i < DATA_W; i = i + 1) begin : g_bitwise
    assign gu[0][i] = bus.op_a[i] & bus.op_b[i];
  end

  ////////////////////////////////////////////////////////////
  // Up-sweep
  ////////////////////////////////////////////////////////////

  // Level lv merges adjacent groups of span 2**(lv-1) at the top
  // position of each aligned block of 2**lv bits
  for (lv = 1; lv <= PREFIX_LEVELS; lv = lv + 1) begin : g_up
    for (i = 0; i < DATA_W; i = i + 1) begin : g_bit
      if (((i + 1) % (1 << lv)) == 0) begin : g_cell
        assign gu[lv][i] = gu[lv-1][i]
                         | (pu[lv-1][i] & gu[lv-1][i - (1 << (lv - 1))]);
        assign pu[lv][i] = pu[lv-1][i] & pu[lv-1][i - (1 << (lv - 1))];
      end else begin : g_pass
        assign gu[lv][i] = gu[lv-1][i];
        assign pu[lv][i] = pu[lv-1][i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Down-sweep
  ////////////////////////////////////////////////////////////

  assign gd[PREFIX_LEVELS] = gu[PREFIX_LEVELS];

  // Fill the middle of each block from the full prefix just below it.
  // Only generate is needed here since the lower term already reaches bit 0
  for (lv = PREFIX_LEVELS - 1; lv >= 1; lv = lv - 1) begin : g_down
    for (i = 0; i < DATA_W; i = i + 1) begin : g_bit
      if ((i >= (1 << lv)) && (((i + 1) % (1 << lv)) == (1 << (lv - 1))))
      begin : g_cell
        assign gd[lv][i] = gd[lv+1][i]
                         | (pu[PREFIX_LEVELS][i] & gd[lv+1][i - (1 << (lv - 1))]);
      end else begin : g_pass
        assign gd[lv][i] = gd[lv+1][i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sum and carry out
  ////////////////////////////////////////////////////////////

  // gd[1][k] is the carry out of bit k
  assign carry_in = {gd[1][DATA_W-2:0], bus.cin};

  assign bus.sum  = pu[0] ^ carry_in;
  assign bus.cout = gd[1][DATA_W-1];

endmodule

// ==== source/arith_unit.sv ====
module arith_unit import adder_pkg::*, arith_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  op_t    op,
  input  data_t  a,
  input  data_t  b,
  adder_if.stage add,
  output logic   out_valid,
  output data_t  result,
  output flags_t flags
);

  // Input register
  logic  s1_valid;
  op_t   s1_op;
  data_t s1_a;
  data_t s1_b;

  // Carry of the most recently completed operation
  logic carry_flag;

  flags_t flags_nxt;
  logic   sign_a;
  logic   sign_b;
  logic   sign_s;

  ////////////////////////////////////////////////////////////
  // Stage 1: request capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_op <= op;
      s1_a  <= a;
      s1_b  <= b;
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand conditioning
  ////////////////////////////////////////////////////////////

  // Subtract is a + ~b + 1; with borrow the +1 comes from the carry flag
  always_comb begin
    add.op_a = s1_a;
    case (s1_op)
      OP_ADD: begin
        add.op_b = s1_b;
        add.cin  = 1'b0;
      end
      OP_ADC: begin
        add.op_b = s1_b;
        add.cin  = carry_flag;
      end
      OP_SUB: begin
        add.op_b = ~s1_b;
        add.cin  = 1'b1;
      end
      default: begin
        add.op_b = ~s1_b;
        add.cin  = carry_flag;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Flags
  ////////////////////////////////////////////////////////////

  assign sign_a = add.op_a[DATA_W-1];
  assign sign_b = add.op_b[DATA_W-1];
  assign sign_s = add.sum[DATA_W-1];

  always_comb begin
    flags_nxt[FLAG_N] = sign_s;
    flags_nxt[FLAG_Z] = (add.sum == '0);
    flags_nxt[FLAG_C] = add.cout;
    // Same-sign operands with a flipped result sign
    flags_nxt[FLAG_V] = (sign_a == sign_b) && (sign_s != sign_a);
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: output register and carry flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      carry_flag <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid) begin
        carry_flag <= add.cout;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result <= add.sum;
      flags  <= flags_nxt;
    end
  end

endmodule

// ==== source/arith_top.sv ====
module arith_top import adder_pkg::*, arith_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  op_t    op,
  input  data_t  a,
  input  data_t  b,
  output logic   out_valid,
  output data_t  result,
  output flags_t flags
);

  // Stage to adder link
  adder_if add_bus ();

  arith_unit u_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .add       (add_bus.stage),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  // Combinational, answers in the same cycle
  brent_kung_adder u_adder (
    .bus (add_bus.adder)
  );

endmodule

// ==== verif/arith_tb.sv ====
module arith_tb import adder_pkg::*, arith_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_VEC      = 64;

  localparam logic [31:0] LFSR_SEED = 32'h2c0a_d2d0;
  // Taps for x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic   clk = 1'b0;
  logic   rst_n = 1'b0;
  logic   in_valid;
  op_t    op;
  data_t  a;
  data_t  b;
  logic   out_valid;
  data_t  result;
  flags_t flags;

  // Vector table
  logic [1:0] vec_op  [MAX_VEC];
  data_t      vec_a   [MAX_VEC];
  data_t      vec_b   [MAX_VEC];
  data_t      vec_res [MAX_VEC];
  flags_t     vec_fl  [MAX_VEC];
  int         num_vec;

  int          total_results  = 0;
  int          rcv_count      = 0;
  int          exp_idx;
  logic        vectors_loaded = 1'b0;
  logic [31:0] lfsr;

  arith_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      stop_with_error($sformatf("Mismatch at time %0t: %s expected %h, got %h",
                               $time, what, expected, actual));
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // Two LFSR bits give an idle gap of 0 to 3 cycles
  task automatic pick_gap(output int gap);
    logic [1:0] bits;
    bits = '0;
    for (int k = 0; k < 2; k++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[0], lfsr[0]};
    end
    gap = int'(bits);
  endtask

  task automatic read_vectors();
    int     fd;
    int     code;
    string  line;
    logic [1:0] t_op;
    data_t  t_a;
    data_t  t_b;
    data_t  t_res;
    flags_t t_fl;
    num_vec = 0;
    fd = $fopen("verif/arith_input.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open the vector file verif/arith_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and blank lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      code = $sscanf(line, "%h %h %h %h %h", t_op, t_a, t_b, t_res, t_fl);
      if (code != 5) begin
        stop_with_error($sformatf("Malformed vector line: %s", line));
      end
      if (num_vec >= MAX_VEC) begin
        stop_with_error("The vector file holds more vectors than the table can store");
      end
      vec_op[num_vec]  = t_op;
      vec_a[num_vec]   = t_a;
      vec_b[num_vec]   = t_b;
      vec_res[num_vec] = t_res;
      vec_fl[num_vec]  = t_fl;
      num_vec++;
    end
    $fclose(fd);
    if (num_vec == 0) begin
      stop_with_error("The vector file holds no vectors");
    end
  endtask

  task automatic drive_request(input int idx);
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b1;
    op       = op_t'(vec_op[idx]);
    a        = vec_a[idx];
    b        = vec_b[idx];
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int gap;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    op       = OP_ADD;
    a        = '0;
    b        = '0;
    lfsr     = LFSR_SEED;

    read_vectors();
    // Each vector runs twice
    total_results  = 2 * num_vec;
    vectors_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // First pass with random idle gaps
    for (int i = 0; i < num_vec; i++) begin
      drive_request(i);
      pick_gap(gap);
      repeat (gap) drive_idle();
    end

    // Second pass back to back, the table ends with carry clear
    for (int i = 0; i < num_vec; i++) begin
      drive_request(i);
    end
    drive_idle();

    wait (rcv_count == total_results);
    // Room for any stray pulse to show up
    repeat (PIPE_LATENCY + 2) @(posedge clk);

    $display("PASS: all tests");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  // Mid-cycle sampling, outputs settle after the rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (out_valid !== 1'b0) begin
        stop_with_error("out_valid was not low during reset");
      end
    end else if (out_valid === 1'b1) begin
      if (rcv_count >= total_results) begin
        stop_with_error("out_valid pulsed with no request outstanding");
      end
      exp_idx = rcv_count % num_vec;
      check_value(result, vec_res[exp_idx], $sformatf("result of vector %0d", exp_idx));
      check_value(data_t'(flags), data_t'(vec_fl[exp_idx]),
                  $sformatf("flags of vector %0d", exp_idx));
      rcv_count++;
    end else if (out_valid !== 1'b0) begin
      stop_with_error("out_valid is unknown after reset");
    end
  end

  initial begin : watchdog
    int limit_cycles;
    wait (vectors_loaded);
    limit_cycles = total_results * (PIPE_LATENCY + 4) + RESET_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    stop_with_error($sformatf("Timeout: results are missing, %0d of %0d arrived",
                              rcv_count, total_results));
  end

endmodule

// ==== build.f ====
source/adder_pkg.sv
source/arith_pkg.sv
source/adder_if.sv
source/brent_kung_adder.sv
source/arith_unit.sv
source/arith_top.sv
verif/arith_tb.sv

// ==== Makefile ====
# Verilator build and run for the add/subtract unit testbench

VERILATOR ?= verilator
TOP       ?= arith_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard source/*.sv) $(wildcard verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/arith_input.txt ====
# op a b result flags, all hex; op 0 add, 1 adc, 2 sub, 3 sbb
# flags are N Z C V from bit 3 down to bit 0
# first adc after reset sees carry 0, then plain add and subtract
1 00000005 00000003 00000008 0
0 00000000 00000000 00000000 4
0 12345678 11111111 23456789 0
2 00000007 00000007 00000000 6
2 00000005 00000007 fffffffe 8
2 00000010 00000001 0000000f 2
# carry across the whole word
0 80000000 80000000 00000000 7
0 ffffffff 00000001 00000000 6
0 ffffffff ffffffff fffffffe a
0 aaaaaaaa 55555555 ffffffff 8
0 55555555 55555555 aaaaaaaa 9
0 aaaaaaaa aaaaaaaa 55555554 3
0 7fffffff 00000001 80000000 9
0 0000ffff 0000ffff 0001fffe 0
0 00ff00ff 00010001 01000100 0
# signed overflow on subtract
2 80000000 00000001 7fffffff 3
2 7fffffff ffffffff 80000000 9
2 00000000 00000001 ffffffff 8
2 00000000 00000000 00000000 6
2 ffffffff 80000000 7fffffff 2
2 00000001 80000000 80000001 9
# 64-bit add and subtract from 32-bit halves
0 ffffffff 00000001 00000000 6
1 00000001 00000002 00000004 0
0 9abcdef0 87654321 22222211 3
1 12345678 0fedcba9 22222222 0
2 00000000 00000001 ffffffff 8
3 00000001 00000000 00000000 6
2 00000005 00000003 00000002 2
3 80000000 00000001 7fffffff 3
# 96-bit chains
0 ffffffff 00000001 00000000 6
1 ffffffff 00000000 00000000 6
1 ffffffff 00000000 00000000 6
1 00000000 00000000 00000001 0
2 00000000 00000001 ffffffff 8
3 00000000 00000000 ffffffff 8
3 00000000 00000000 ffffffff 8
# carry flag reuse by adc and sbb
1 00000003 00000004 00000007 0
3 00000010 00000004 0000000b 2
3 00000010 00000004 0000000c 2
1 7fffffff 00000000 80000000 9
1 7fffffff 00000000 7fffffff 0
2 3c3c3c3c c3c3c3c3 78787879 0
0 f0f0f0f0 0f0f0f10 00000000 6
1 00000000 ffffffff 00000000 6
3 00000000 00000000 00000000 6
0 00000001 00000001 00000002 0
